//--- verif/dcache_testdata.hex
// op_addr_wdata_mask_expectedrdata_expectedhit, one operation per line
// op 01 is a read, 02 a write, 03 a flush
02_0000000000001000_1122334455667788_ff_0000000000000000_00
01_0000000000001000_0000000000000000_00_1122334455667788_00
01_0000000000001000_0000000000000000_00_1122334455667788_00
01_0000000080001000_0000000000000000_00_1122334455667788_00
01_0000000080001000_0000000000000000_00_1122334455667788_01
02_0000000000000040_a0a1a2a3a4a5a6a7_ff_0000000000000000_00
01_0000000080000040_0000000000000000_00_a0a1a2a3a4a5a6a7_00
01_0000000080000040_0000000000000000_00_a0a1a2a3a4a5a6a7_01
02_0000000080000040_0102030405060708_0f_0000000000000000_01
01_0000000080000040_0000000000000000_00_a0a1a2a305060708_01
02_0000000080000040_ffeeddccbbaa9988_a5_0000000000000000_01
01_0000000080000040_0000000000000000_00_ffa1dda305aa0788_01
01_0000000000000040_0000000000000000_00_ffa1dda305aa0788_00
02_0000000080000080_0123456789abcdef_3c_0000000000000000_00
01_0000000080000080_0000000000000000_00_0000456789ab0000_00
01_0000000080000080_0000000000000000_00_0000456789ab0000_01
02_00000000000000c0_00000000aaaaaaaa_ff_0000000000000000_00
02_00000000000002c0_00000000bbbbbbbb_ff_0000000000000000_00
02_00000000000004c0_00000000cccccccc_ff_0000000000000000_00
01_00000000800000c0_0000000000000000_00_00000000aaaaaaaa_00
01_00000000800002c0_0000000000000000_00_00000000bbbbbbbb_00
01_00000000800004c0_0000000000000000_00_00000000cccccccc_00
01_00000000800002c0_0000000000000000_00_00000000bbbbbbbb_01
01_00000000800004c0_0000000000000000_00_00000000cccccccc_01
01_00000000800000c0_0000000000000000_00_00000000aaaaaaaa_00
01_00000000800004c0_0000000000000000_00_00000000cccccccc_00
01_00000000800002c0_0000000000000000_00_00000000bbbbbbbb_01
03_0000000000000000_0000000000000000_00_0000000000000000_00
01_0000000080001000_0000000000000000_00_1122334455667788_00
01_0000000080001000_0000000000000000_00_1122334455667788_01
01_0000000080000040_0000000000000000_00_ffa1dda305aa0788_00
01_0000000080000040_0000000000000000_00_ffa1dda305aa0788_01
01_00000000800002c0_0000000000000000_00_00000000bbbbbbbb_00
01_00000000800002c0_0000000000000000_00_00000000bbbbbbbb_01

//--- dcache_sys.f
common/dcache_pkg.sv
dcache/dcache_data_ram.sv
dcache/dcache_tags.sv
dcache/dcache_ctrl.sv
source/main_mem.sv
source/dcache_sys.sv
verif/tb_dcache_sys.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_dcache_sys -f dcache_sys.f \
        -o sim_dcache_sys \
    && ./obj_dir/sim_dcache_sys | tee /dev/stderr | grep -q "TEST PASS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- verif/tb_dcache_sys.sv
`timescale 1ns/1ps

module tb_dcache_sys;

    localparam int mem_latency  = 4;
    localparam int clk_period   = 8;
    localparam int reset_cycles = 16;
    localparam int max_records  = 64;

    localparam logic [7:0] op_read  = 8'h01;
    localparam logic [7:0] op_write = 8'h02;
    localparam logic [7:0] op_flush = 8'h03;

    logic        clk = 1'b0;
    logic        rst;
    logic        req;
    logic [63:0] addr;
    logic [63:0] wdata;
    logic [7:0]  mask;
    logic        wen;
    logic        flush;
    logic        resp;
    logic [63:0] rdata;
    logic        hit;

    // Each record is op, addr, wdata, mask, expected rdata, expected hit
    logic [215:0] records [max_records];
    int           num_records = 0;
    int           errors      = 0;
    int           tests_run   = 0;
    logic         loaded      = 1'b0;

    dcache_sys #(
        .MEM_LATENCY (mem_latency)
    ) dut0 (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .addr  (addr),
        .wdata (wdata),
        .mask  (mask),
        .wen   (wen),
        .flush (flush),
        .resp  (resp),
        .rdata (rdata),
        .hit   (hit)
    );

    always #(clk_period / 2) clk = ~clk;

    function automatic string op_name(input logic [7:0] op);
        case (op)
            op_read:  return "read ";
            op_write: return "write";
            op_flush: return "flush";
            default:  return "???  ";
        endcase
    endfunction

    task automatic check_data(input string name, input logic [63:0] got,
                              input logic [63:0] expected);
        if (got !== expected) begin
            $display("MISMATCH %s got %h expected %h", name, got, expected);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic expected);
        if (got !== expected) begin
            $display("MISMATCH %s got %h expected %h", name, got, expected);
            errors++;
        end
    endtask

    // Starts on a falling edge and returns on the falling edge after the response
    task automatic run_access(input logic [63:0] a, input logic [63:0] d,
                              input logic [7:0] m, input logic w,
                              output logic [63:0] got_data, output logic got_hit,
                              output int cycles);
        addr  = a;
        wdata = d;
        mask  = m;
        wen   = w;
        req   = 1'b1;
        @(negedge clk);
        req    = 1'b0;
        cycles = 1;
        while (resp !== 1'b1) begin
            @(negedge clk);
            cycles++;
        end
        got_data = rdata;
        got_hit  = hit;
        // The controller is back in idle only after the response cycle ends
        @(negedge clk);
    endtask

    task automatic run_record(input int idx);
        logic [7:0]  op;
        logic [63:0] rec_addr;
        logic [63:0] rec_wdata;
        logic [7:0]  rec_mask;
        logic [63:0] exp_rdata;
        logic        exp_hit;
        logic [63:0] got_data;
        logic        got_hit;
        int          cycles;
        int          errors_before;
        op            = records[idx][215:208];
        rec_addr      = records[idx][207:144];
        rec_wdata     = records[idx][143:80];
        rec_mask      = records[idx][79:72];
        exp_rdata     = records[idx][71:8];
        exp_hit       = records[idx][0];
        errors_before = errors;
        case (op)
            op_flush: begin
                flush = 1'b1;
                @(negedge clk);
                flush = 1'b0;
            end
            op_read, op_write: begin
                run_access(rec_addr, rec_wdata, rec_mask, op == op_write,
                           got_data, got_hit, cycles);
                check_data("rdata", got_data, exp_rdata);
                check_flag("hit", got_hit, exp_hit);
                // A read hit answers in the cycle after the request
                if (op == op_read && exp_hit && cycles != 1) begin
                    $display("read hit in test %0d answered after %0d cycles instead of 1",
                             idx, cycles);
                    errors++;
                end
            end
            default: begin
                $display("test %0d has an unknown operation code %h", idx, op);
                errors++;
            end
        endcase
        tests_run++;
        $display("test %0d %s addr %h: %s", idx, op_name(op), rec_addr,
                 (errors == errors_before) ? "ok" : "failed");
    endtask

    initial begin
        rst   = 1'b0;
        req   = 1'b0;
        addr  = 64'd0;
        wdata = 64'd0;
        mask  = 8'd0;
        wen   = 1'b0;
        flush = 1'b0;
        for (int i = 0; i < max_records; i++) begin
            records[i] = '0;
        end
        $readmemh("verif/dcache_testdata.hex", records);
        while (num_records < max_records && records[num_records][215:208] != 8'h00) begin
            num_records++;
        end
        loaded = 1'b1;
        if (num_records == 0) begin
            $display("no test records were loaded from the data file");
            errors++;
        end
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        @(negedge clk);
        for (int i = 0; i < num_records; i++) begin
            run_record(i);
        end
        $display("%0d tests run, %0d errors", tests_run, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Every record fits in MEM_LATENCY+4 cycles, so twice that plus reset is ample
    initial begin
        int limit_cycles;
        wait (loaded === 1'b1);
        limit_cycles = (num_records * (mem_latency + 4) + reset_cycles) * 2;
        #(limit_cycles * clk_period);
        $display("watchdog expired after %0d cycles, the DUT stopped responding", limit_cycles);
        $display("TEST FAIL");
        $finish;
    end

endmodule

//--- source/dcache_sys.sv
`timescale 1ns/1ps

module dcache_sys #(
    parameter int MEM_LATENCY = 4
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        req,
    input  logic [63:0] addr,
    input  logic [63:0] wdata,
    input  logic [7:0]  mask,
    input  logic        wen,
    input  logic        flush,
    output logic        resp,
    output logic [63:0] rdata,
    output logic        hit
);

    logic                           hit_way0;
    logic                           hit_way1;
    logic                           valid_way0;
    logic                           valid_way1;
    logic [dcache_pkg::index_w-1:0] lookup_index;
    logic [dcache_pkg::tag_w-1:0]   lookup_tag;
    logic                           fill_en;
    logic                           fill_way;
    logic [dcache_pkg::index_w-1:0] fill_index;
    logic [dcache_pkg::tag_w-1:0]   fill_tag;
    logic [dcache_pkg::index_w-1:0] ram_addr;
    logic [127:0]                   ram_wdata;
    logic [127:0]                   ram_rdata;
    logic [15:0]                    ram_byte_en;
    logic                           ram_we;
    logic                           mem_req;
    logic [63:0]                    mem_addr;
    logic [63:0]                    mem_wdata;
    logic [7:0]                     mem_mask;
    logic                           mem_wen;
    logic                           mem_ack;
    logic [63:0]                    mem_rdata;

    dcache_ctrl ctrl0 (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .addr         (addr),
        .wdata        (wdata),
        .mask         (mask),
        .wen          (wen),
        .hit_way0     (hit_way0),
        .hit_way1     (hit_way1),
        .valid_way0   (valid_way0),
        .valid_way1   (valid_way1),
        .ram_rdata    (ram_rdata),
        .mem_ack      (mem_ack),
        .mem_rdata    (mem_rdata),
        .resp         (resp),
        .rdata        (rdata),
        .hit          (hit),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .fill_en      (fill_en),
        .fill_way     (fill_way),
        .fill_index   (fill_index),
        .fill_tag     (fill_tag),
        .ram_addr     (ram_addr),
        .ram_wdata    (ram_wdata),
        .ram_byte_en  (ram_byte_en),
        .ram_we       (ram_we),
        .mem_req      (mem_req),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_mask     (mem_mask),
        .mem_wen      (mem_wen)
    );

    dcache_tags tags0 (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .lookup_index (lookup_index),
        .lookup_tag   (lookup_tag),
        .fill_en      (fill_en),
        .fill_way     (fill_way),
        .fill_index   (fill_index),
        .fill_tag     (fill_tag),
        .hit_way0     (hit_way0),
        .hit_way1     (hit_way1),
        .valid_way0   (valid_way0),
        .valid_way1   (valid_way1)
    );

    dcache_data_ram ram0 (
        .clk         (clk),
        .ram_addr    (ram_addr),
        .ram_wdata   (ram_wdata),
        .ram_byte_en (ram_byte_en),
        .ram_we      (ram_we),
        .ram_rdata   (ram_rdata)
    );

    main_mem #(
        .MEM_LATENCY (MEM_LATENCY)
    ) mem0 (
        .clk       (clk),
        .rst       (rst),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_mask  (mem_mask),
        .mem_wen   (mem_wen),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

endmodule

//--- source/main_mem.sv
`timescale 1ns/1ps

module main_mem #(
    parameter int MEM_LATENCY = 4
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        mem_req,
    input  logic [63:0] mem_addr,
    input  logic [63:0] mem_wdata,
    input  logic [7:0]  mem_mask,
    input  logic        mem_wen,
    output logic        mem_ack,
    output logic [63:0] mem_rdata
);

    localparam int word_w = $clog2(dcache_pkg::mem_words);
    localparam int cnt_w  = $clog2(MEM_LATENCY + 1);

    logic [63:0]       mem [dcache_pkg::mem_words] = '{default: 64'd0};
    logic [word_w-1:0] word_idx;
    logic [cnt_w-1:0]  cnt;

    // Bits 2:0 are ignored and upper bits alias
    assign word_idx = mem_addr[dcache_pkg::offset_w +: word_w];

    always_ff @(posedge clk) begin
        if (mem_req) begin
            if (mem_wen) begin
                for (int b = 0; b < 8; b++) begin
                    if (mem_mask[b]) begin
                        mem[word_idx][b*8 +: 8] <= mem_wdata[b*8 +: 8];
                    end
                end
            end else begin
                mem_rdata <= mem[word_idx];
            end
        end
    end

    // Counter loads on acceptance and ack is raised on its last count,
    // which puts ack MEM_LATENCY cycles after the request cycle
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cnt <= '0;
        end else if (mem_req) begin
            cnt <= cnt_w'(MEM_LATENCY);
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    assign mem_ack = (cnt == cnt_w'(1));

endmodule

//--- dcache/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           req,
    input  logic [63:0]                    addr,
    input  logic [63:0]                    wdata,
    input  logic [7:0]                     mask,
    input  logic                           wen,
    input  logic                           hit_way0,
    input  logic                           hit_way1,
    input  logic                           valid_way0,
    input  logic                           valid_way1,
    input  logic [127:0]                   ram_rdata,
    input  logic                           mem_ack,
    input  logic [63:0]                    mem_rdata,
    output logic                           resp,
    output logic [63:0]                    rdata,
    output logic                           hit,
    output logic [dcache_pkg::index_w-1:0] lookup_index,
    output logic [dcache_pkg::tag_w-1:0]   lookup_tag,
    output logic                           fill_en,
    output logic                           fill_way,
    output logic [dcache_pkg::index_w-1:0] fill_index,
    output logic [dcache_pkg::tag_w-1:0]   fill_tag,
    output logic [dcache_pkg::index_w-1:0] ram_addr,
    output logic [127:0]                   ram_wdata,
    output logic [15:0]                    ram_byte_en,
    output logic                           ram_we,
    output logic                           mem_req,
    output logic [63:0]                    mem_addr,
    output logic [63:0]                    mem_wdata,
    output logic [7:0]                     mem_mask,
    output logic                           mem_wen
);

    localparam logic [1:0] st_idle      = 2'd0;
    localparam logic [1:0] st_hit_reply = 2'd1;
    localparam logic [1:0] st_mem_wait  = 2'd2;
    localparam logic [1:0] st_reply     = 2'd3;

    logic [1:0]        state;
    dcache_pkg::addr_u in_a;
    dcache_pkg::addr_u req_a;
    logic              cacheable;
    logic              lookup_hit;
    logic              hit_q;
    logic              fill_q;
    logic              hit_way_q;
    logic              fill_way_q;
    logic [63:0]       wdata_q;
    logic [7:0]        mask_q;
    logic              wen_q;
    logic [63:0]       rdata_q;
    logic              hit_wr;
    logic              fill_wr;

    assign in_a.raw = addr;

    assign cacheable  = (in_a.raw >= dcache_pkg::cache_base) &&
                        (in_a.raw <= dcache_pkg::cache_limit);
    assign lookup_hit = cacheable && (hit_way0 || hit_way1);

    // Lookup runs straight off the incoming address in the request cycle
    assign lookup_index = in_a.fields.index;
    assign lookup_tag   = in_a.fields.tag;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state   <= st_idle;
            mem_req <= 1'b0;
            hit_q   <= 1'b0;
            fill_q  <= 1'b0;
        end else begin
            mem_req <= 1'b0;
            case (state)
                st_idle: begin
                    if (req) begin
                        hit_q  <= lookup_hit;
                        fill_q <= cacheable && !wen && !lookup_hit;
                        if (lookup_hit && !wen) begin
                            state <= st_hit_reply;
                        end else begin
                            state   <= st_mem_wait;
                            mem_req <= 1'b1;
                        end
                    end
                end
                st_hit_reply: begin
                    state <= st_idle;
                end
                st_mem_wait: begin
                    if (mem_ack) begin
                        state <= st_reply;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && req) begin
            req_a   <= in_a;
            wdata_q <= wdata;
            mask_q  <= mask;
            wen_q   <= wen;
            // Way 1 only when it is the hitting way
            hit_way_q  <= hit_way1;
            // Way 0 if invalid, else way 1 if invalid, else way 0
            fill_way_q <= valid_way0 && !valid_way1;
        end
        if (state == st_mem_wait && mem_ack) begin
            rdata_q <= wen_q ? 64'd0 : mem_rdata;
        end
    end

    // A write hit updates the RAM in the same cycle the write goes to memory
    assign hit_wr  = (state == st_mem_wait) && mem_req && wen_q && hit_q;
    assign fill_wr = (state == st_mem_wait) && mem_ack && fill_q;

    assign ram_we   = hit_wr || fill_wr;
    assign ram_addr = (state == st_idle) ? in_a.fields.index : req_a.fields.index;

    assign ram_wdata = fill_wr ? {mem_rdata, mem_rdata} : {wdata_q, wdata_q};

    always_comb begin
        if (fill_wr) begin
            ram_byte_en = fill_way_q ? 16'hff00 : 16'h00ff;
        end else if (hit_wr) begin
            ram_byte_en = hit_way_q ? {mask_q, 8'h00} : {8'h00, mask_q};
        end else begin
            ram_byte_en = 16'h0000;
        end
    end

    assign fill_en    = fill_wr;
    assign fill_way   = fill_way_q;
    assign fill_index = req_a.fields.index;
    assign fill_tag   = req_a.fields.tag;

    assign mem_addr  = req_a.raw;
    assign mem_wdata = wdata_q;
    assign mem_mask  = mask_q;
    assign mem_wen   = wen_q;

    assign resp = (state == st_hit_reply) || (state == st_reply);
    assign hit  = resp && hit_q;

    always_comb begin
        if (state == st_hit_reply) begin
            rdata = hit_way_q ? ram_rdata[127:64] : ram_rdata[63:0];
        end else if (state == st_reply) begin
            rdata = rdata_q;
        end else begin
            rdata = 64'd0;
        end
    end

endmodule

//--- dcache/dcache_tags.sv
`timescale 1ns/1ps

module dcache_tags (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           flush,
    input  logic [dcache_pkg::index_w-1:0] lookup_index,
    input  logic [dcache_pkg::tag_w-1:0]   lookup_tag,
    input  logic                           fill_en,
    input  logic                           fill_way,
    input  logic [dcache_pkg::index_w-1:0] fill_index,
    input  logic [dcache_pkg::tag_w-1:0]   fill_tag,
    output logic                           hit_way0,
    output logic                           hit_way1,
    output logic                           valid_way0,
    output logic                           valid_way1
);

    logic [dcache_pkg::num_sets-1:0] valid [2];
    logic [dcache_pkg::tag_w-1:0]    tags  [2][dcache_pkg::num_sets];

    assign valid_way0 = valid[0][lookup_index];
    assign valid_way1 = valid[1][lookup_index];

    assign hit_way0 = valid_way0 && (tags[0][lookup_index] == lookup_tag);
    assign hit_way1 = valid_way1 && (tags[1][lookup_index] == lookup_tag);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid[0] <= '0;
            valid[1] <= '0;
        end else if (flush) begin
            // Flush only comes while idle, so it never meets a fill
            valid[0] <= '0;
            valid[1] <= '0;
        end else if (fill_en) begin
            valid[fill_way][fill_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tags[fill_way][fill_index] <= fill_tag;
        end
    end

endmodule

//--- dcache/dcache_data_ram.sv
`timescale 1ns/1ps

module dcache_data_ram (
    input  logic                           clk,
    input  logic [dcache_pkg::index_w-1:0] ram_addr,
    input  logic [127:0]                   ram_wdata,
    input  logic [15:0]                    ram_byte_en,
    input  logic                           ram_we,
    output logic [127:0]                   ram_rdata
);

    // Way 0 sits in the low half of each entry, way 1 in the high half
    logic [127:0] mem [dcache_pkg::num_sets];

    always_ff @(posedge clk) begin
        if (ram_we) begin
            for (int b = 0; b < 16; b++) begin
                if (ram_byte_en[b]) begin
                    mem[ram_addr][b*8 +: 8] <= ram_wdata[b*8 +: 8];
                end
            end
        end
        // Read returns the old contents when the same entry is written
        ram_rdata <= mem[ram_addr];
    end

endmodule

//--- common/dcache_pkg.sv
package dcache_pkg;

    // Two ways of 64 single-word lines
    localparam int num_sets = 64;
    localparam int index_w  = 6;
    localparam int offset_w = 3;
    localparam int tag_w    = 55;

    // Inclusive bounds of the cacheable window
    localparam logic [63:0] cache_base  = 64'h0000_0000_8000_0000;
    localparam logic [63:0] cache_limit = 64'h0000_0000_8fff_ffff;

    // Backing store depth in 8-byte words, so addresses alias every 32 KiB
    localparam int mem_words = 4096;

    typedef struct packed {
        logic [tag_w-1:0]    tag;
        logic [index_w-1:0]  index;
        logic [offset_w-1:0] offset;
    } addr_fields_t;

    // The same address word, read as a number or as lookup fields
    typedef union packed {
        logic [63:0]  raw;
        addr_fields_t fields;
    } addr_u;

endpackage
